//--- Makefile
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= bp_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif grep -q "Verification passed" $(LOG); then \
	  echo "Simulation PASSED"; \
	else \
	  echo "No verdict found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+include
logic/bp_pkg.sv
logic/bp_counter_ram.sv
logic/bp_predict_stage.sv
logic/bp_resolve_stage.sv
logic/bp_top.sv
tests/bp_tb.sv

//--- include/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

////////////////////////////////////////////////////////////
// Predictor geometry
////////////////////////////////////////////////////////////

// Program counter width
`define BP_XLEN 32

// Global history length with the newest outcome in bit 0
`define BP_GLOBAL_BITS 2

// PC slice used next to the history in the table index
`define BP_LOCAL_BITS 4
`define BP_LOCAL_LSB 2

// Held fetch PC after reset
`define BP_PC_INIT 32'h8000_0000

`endif

//--- logic/bp_counter_ram.sv
`timescale 1ns/1ps

module bp_counter_ram
  import bp_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // Write port from resolve
  input  bp_update_t upd_i,
  // Read port from fetch
  input  bp_idx_t    raddr_i,
  output bp_cnt_t    rdata_o
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // One counter per history/PC combination
  localparam int unsigned DEPTH = 2 ** $bits(bp_idx_t);

  bp_cnt_t mem_q [DEPTH];
  // Registered read data
  bp_cnt_t rdata_q;

  ////////////////////////////////////////////////////////////
  // Read and write
  ////////////////////////////////////////////////////////////

  // Whole table starts weakly not taken.
  // Read samples the array before this edge's write lands,
  // so a same-index collision returns the old counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= BP_CNT_WNT;
      end
      rdata_q <= BP_CNT_WNT;
    end else begin
      // Read every cycle with one cycle of latency
      rdata_q <= mem_q[raddr_i];
      // Write strobe from resolve
      if (upd_i.we) begin
        mem_q[upd_i.idx] <= upd_i.cnt;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- logic/bp_pkg.sv
`include "bp_config.svh"

package bp_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [`BP_XLEN-1:0] bp_pc_t;
  typedef logic [`BP_GLOBAL_BITS-1:0] bp_hist_t;
  // History in the upper bits, PC slice in the lower bits
  typedef logic [`BP_GLOBAL_BITS+`BP_LOCAL_BITS-1:0] bp_idx_t;
  // 00 SNT, 01 WNT, 11 WT, 10 ST; bit 1 is the prediction
  typedef logic [1:0] bp_cnt_t;

  // Encodings that the stages refer to by name
  localparam bp_cnt_t BP_CNT_WNT = 2'b01;
  localparam bp_cnt_t BP_CNT_ST = 2'b10;

  ////////////////////////////////////////////////////////////
  // Stage-to-stage bundles
  ////////////////////////////////////////////////////////////

  // Table write from the resolve stage
  typedef struct packed {
    bp_idx_t idx;
    bp_cnt_t cnt;
    logic we;
  } bp_update_t;

  // Resolved branch coming back from execute
  typedef struct packed {
    logic valid;
    bp_pc_t pc;
    bp_cnt_t predict;
    logic taken;
  } bp_resolve_t;

endpackage

//--- logic/bp_predict_stage.sv
`timescale 1ns/1ps

`include "bp_config.svh"

module bp_predict_stage
  import bp_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // Fetch side
  input  logic     id_stall_i,
  input  bp_pc_t   if_pc_i,
  // Current global history from resolve
  input  bp_hist_t hist_i,
  // Counter table read port
  input  bp_cnt_t  rdata_i,
  output bp_idx_t  raddr_o,
  // Prediction back to fetch
  output bp_cnt_t  bp_predict_o
);

  ////////////////////////////////////////////////////////////
  // Held fetch PC
  ////////////////////////////////////////////////////////////

  // Last PC accepted while decode was running
  bp_pc_t pc_held_q;
  // PC actually used for the lookup this cycle
  bp_pc_t pc_sel;
  // PC bits that go into the index
  logic [`BP_LOCAL_BITS-1:0] pc_slice;

  // Capture only when not stalled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_held_q <= `BP_PC_INIT;
    end else if (!id_stall_i) begin
      pc_held_q <= if_pc_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read index
  ////////////////////////////////////////////////////////////

  // Stalled fetch keeps asking for the held PC
  always_comb begin
    if (id_stall_i) begin
      pc_sel = pc_held_q;
    end else begin
      pc_sel = if_pc_i;
    end
  end

  // Skip the low instruction-alignment bits
  assign pc_slice = pc_sel[`BP_LOCAL_LSB +: `BP_LOCAL_BITS];

  // History always comes live from resolve
  // even during a stall
  assign raddr_o = {hist_i, pc_slice};

  ////////////////////////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////////////////////////

  // Table read lands one cycle after the index,
  // i.e. one cycle after the PC was presented
  assign bp_predict_o = rdata_i;

endmodule

//--- logic/bp_resolve_stage.sv
`timescale 1ns/1ps

`include "bp_config.svh"

module bp_resolve_stage
  import bp_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Resolved branch from execute
  input  bp_resolve_t res_i,
  // Global history towards fetch
  output bp_hist_t    hist_o,
  // Counter table write
  output bp_update_t  upd_o,
  // Misprediction flag and running count
  output logic        mispredict_o,
  output logic [15:0] mispredict_cnt_o
);

  ////////////////////////////////////////////////////////////
  // Counter update
  ////////////////////////////////////////////////////////////

  // Global history register
  bp_hist_t hist_q;
  // Next counter for the resolved branch
  bp_cnt_t cnt_next;
  // Saturating misprediction counter
  logic [15:0] miss_cnt_q;
  logic miss;

  // Gray-style walk 00 <-> 01 <-> 11 <-> 10, saturating at both ends
  assign cnt_next[0] = res_i.predict[1] ^ res_i.taken;
  assign cnt_next[1] = (res_i.predict == BP_CNT_ST) | (res_i.taken & res_i.predict[0]);

  // Index uses the history before this outcome is shifted in
  assign upd_o.idx = {hist_q, res_i.pc[`BP_LOCAL_LSB +: `BP_LOCAL_BITS]};
  assign upd_o.cnt = cnt_next;
  assign upd_o.we  = res_i.valid;

  ////////////////////////////////////////////////////////////
  // Global history
  ////////////////////////////////////////////////////////////

  // Newest outcome enters at bit 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else if (res_i.valid) begin
      hist_q <= {hist_q[$bits(bp_hist_t)-2:0], res_i.taken};
    end
  end

  assign hist_o = hist_q;

  ////////////////////////////////////////////////////////////
  // Misprediction tracking
  ////////////////////////////////////////////////////////////

  // Carried prediction bit against the real outcome
  assign miss = res_i.valid & (res_i.predict[1] != res_i.taken);

  // Count sticks at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_cnt_q <= '0;
    end else if (miss && (miss_cnt_q != '1)) begin
      miss_cnt_q <= miss_cnt_q + 16'd1;
    end
  end

  // Combinational flag in the same cycle as the resolve
  assign mispredict_o     = miss;
  assign mispredict_cnt_o = miss_cnt_q;

endmodule

//--- logic/bp_top.sv
`timescale 1ns/1ps

module bp_top
  import bp_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Fetch
  input  logic        id_stall_i,
  input  bp_pc_t      if_pc_i,
  // Execute
  input  bp_resolve_t res_i,
  // Prediction and status
  output bp_cnt_t     bp_predict_o,
  output logic        mispredict_o,
  output logic [15:0] mispredict_cnt_o,
  output bp_hist_t    history_o
);

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  bp_hist_t   hist;
  bp_update_t upd;
  bp_idx_t    raddr;
  bp_cnt_t    rdata;

  ////////////////////////////////////////////////////////////
  // Fetch side
  ////////////////////////////////////////////////////////////

  bp_predict_stage predict_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .id_stall_i   (id_stall_i),
    .if_pc_i      (if_pc_i),
    .hist_i       (hist),
    .rdata_i      (rdata),
    .raddr_o      (raddr),
    .bp_predict_o (bp_predict_o)
  );

  // Counter table
  bp_counter_ram ram_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .upd_i   (upd),
    .raddr_i (raddr),
    .rdata_o (rdata)
  );

  ////////////////////////////////////////////////////////////
  // Execute side
  ////////////////////////////////////////////////////////////

  bp_resolve_stage resolve_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .res_i            (res_i),
    .hist_o           (hist),
    .upd_o            (upd),
    .mispredict_o     (mispredict_o),
    .mispredict_cnt_o (mispredict_cnt_o)
  );

  // History also visible outside
  assign history_o = hist;

endmodule

//--- tests/bp_golden.txt
# test stall if_pc res_valid res_pc res_cnt res_taken exp_pred exp_miss exp_cnt exp_hist
# test number decimal, rest hex; counters 0 SNT 1 WNT 3 WT 2 ST; one line per clock cycle
1 0 80000010 0 00000000 0 0 1 0 0000 0
1 0 80000020 0 00000000 0 0 1 0 0000 0
1 0 8000003c 0 00000000 0 0 1 0 0000 0
2 0 80000010 1 80000010 1 1 1 1 0001 1
2 0 80000010 1 80000010 1 1 1 1 0002 3
2 0 80000010 1 80000010 1 1 1 1 0003 3
2 0 80000010 1 80000010 3 1 3 0 0003 3
2 0 80000010 1 80000010 2 1 2 0 0003 3
2 0 80000010 0 00000000 0 0 2 0 0003 3
2 0 80000010 1 80000004 1 0 2 0 0003 2
2 0 80000010 1 80000004 1 0 1 0 0003 0
2 0 80000010 1 80000010 3 0 3 1 0004 0
2 0 80000010 1 80000010 1 0 1 0 0004 0
2 0 80000010 1 80000010 0 0 0 0 0004 0
2 0 80000010 0 00000000 0 0 0 0 0004 0
3 0 80000010 1 80000004 1 1 0 1 0005 1
3 0 80000010 1 80000004 1 1 3 1 0006 3
3 0 80000010 0 00000000 0 0 2 0 0006 3
3 0 80000010 1 80000004 0 0 2 0 0006 2
3 0 80000010 0 00000000 0 0 1 0 0006 2
4 0 80000010 0 00000000 0 0 1 0 0006 2
4 1 80000004 0 00000000 0 0 1 0 0006 2
4 1 80000044 0 00000000 0 0 1 0 0006 2
4 0 80000004 0 00000000 0 0 0 0 0006 2
5 0 8000003c 1 80000020 1 0 1 0 0006 0
5 0 8000003c 1 80000020 1 1 1 1 0007 1
5 0 8000003c 0 80000020 2 0 1 0 0007 1
5 0 8000003c 1 80000020 2 0 1 1 0008 2
5 0 80000020 0 00000000 0 0 0 0 0008 2

//--- tests/bp_tb.sv
`timescale 1ns/1ps

module bp_tb
  import bp_pkg::*;
();

  ////////////////////////////////////////////////////////////
  // Settings and golden row layout
  ////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int SLACK_CYCLES = 32;
  localparam string GOLDEN_FILE = "tests/bp_golden.txt";

  // Stimulus first, expected outputs after
  typedef struct packed {
    int          test;
    logic        stall;
    bp_pc_t      pc;
    logic        res_valid;
    bp_pc_t      res_pc;
    bp_cnt_t     res_cnt;
    logic        res_taken;
    bp_cnt_t     exp_pred;
    logic        exp_miss;
    logic [15:0] exp_cnt;
    bp_hist_t    exp_hist;
  } vec_t;

  logic        clk;
  logic        rst_n;
  logic        id_stall;
  bp_pc_t      if_pc;
  bp_resolve_t res;
  bp_cnt_t     bp_predict;
  logic        mispredict;
  logic [15:0] mispredict_cnt;
  bp_hist_t    history;

  vec_t vec_q[$];
  int   cycle_cnt;
  int   cycle_limit;
  // Per test and overall bookkeeping
  int   test_err;
  int   err_total;
  int   tests_passed;
  int   tests_failed;

  bp_top dut_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .id_stall_i       (id_stall),
    .if_pc_i          (if_pc),
    .res_i            (res),
    .bp_predict_o     (bp_predict),
    .mispredict_o     (mispredict),
    .mispredict_cnt_o (mispredict_cnt),
    .history_o        (history)
  );

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Watchdog over reset plus one cycle per golden row and some slack
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Lines starting with # are comments and get skipped
  task automatic load_golden(output int ok);
    int      fd;
    int      code;
    string   line;
    int      test_num;
    logic    stall;
    bp_pc_t  pc;
    logic    valid;
    bp_pc_t  rpc;
    bp_cnt_t cnt;
    logic    taken;
    bp_cnt_t pred;
    logic    miss;
    logic [15:0] count;
    bp_hist_t hist;
    vec_t    v;
    fd = $fopen(GOLDEN_FILE, "r");
    ok = (fd != 0) ? 1 : 0;
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.getc(0) != "#") begin
          code = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", test_num, stall, pc,
                         valid, rpc, cnt, taken, pred, miss, count, hist);
          if (code == 11) begin
            v = '{test_num, stall, pc, valid, rpc, cnt, taken, pred, miss, count, hist};
            vec_q.push_back(v);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_inputs(input vec_t v);
    id_stall    = v.stall;
    if_pc       = v.pc;
    res.valid   = v.res_valid;
    res.pc      = v.res_pc;
    res.predict = v.res_cnt;
    res.taken   = v.res_taken;
  endtask

  task automatic check_outputs(input vec_t v);
    if (bp_predict !== v.exp_pred) begin
      $display("MISMATCH t=%0t bp_predict_o expected %h actual %h",
               $time, v.exp_pred, bp_predict);
      test_err++;
    end
    if (mispredict !== v.exp_miss) begin
      $display("MISMATCH t=%0t mispredict_o expected %h actual %h",
               $time, v.exp_miss, mispredict);
      test_err++;
    end
    if (mispredict_cnt !== v.exp_cnt) begin
      $display("MISMATCH t=%0t mispredict_cnt_o expected %h actual %h",
               $time, v.exp_cnt, mispredict_cnt);
      test_err++;
    end
    if (history !== v.exp_hist) begin
      $display("MISMATCH t=%0t history_o expected %h actual %h",
               $time, v.exp_hist, history);
      test_err++;
    end
  endtask

  function automatic string test_name(input int num);
    case (num)
      1: test_name = "reset state";
      2: test_name = "counter training";
      3: test_name = "history correlation";
      4: test_name = "stall hold";
      5: test_name = "misprediction counting";
      default: test_name = "unnamed";
    endcase
  endfunction

  task automatic report_test(input int num);
    if (test_err == 0) begin
      $display("test %0d (%s): PASS", num, test_name(num));
      tests_passed++;
    end else begin
      $display("test %0d (%s): FAIL with %0d errors", num, test_name(num), test_err);
      tests_failed++;
    end
    err_total += test_err;
    test_err = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int   loaded;
    int   cur_test;
    vec_t v;
    cycle_cnt    = 0;
    test_err     = 0;
    err_total    = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    id_stall     = 1'b0;
    if_pc        = '0;
    res          = '0;
    load_golden(loaded);
    cycle_limit = RESET_CYCLES + vec_q.size() + SLACK_CYCLES;
    if (loaded == 0) begin
      $display("ERROR: cannot open golden file %s", GOLDEN_FILE);
      tests_failed++;
    end else if (vec_q.size() == 0) begin
      $display("ERROR: golden file %s holds no rows", GOLDEN_FILE);
      tests_failed++;
    end
    // Reset released on a falling edge
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    cur_test = -1;
    foreach (vec_q[i]) begin
      v = vec_q[i];
      if (cur_test >= 0 && v.test != cur_test) begin
        report_test(cur_test);
      end
      cur_test = v.test;
      drive_inputs(v);
      @(posedge clk);
      // Outputs settled after the edge while inputs are still held
      #1;
      check_outputs(v);
      @(negedge clk);
    end
    if (cur_test >= 0) begin
      report_test(cur_test);
    end
    $display("Tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, err_total);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
